//--- hw/bank_rr_arbiter.sv
/*
 * per-bank round-robin arbiter
 * picks one core among those addressing this bank and forms the
 * bank request and a one-hot winner vector
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module bank_rr_arbiter import cluster_intc_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  core_req_t                core_req_i [`NB_CORES],
  input  decode_t                  dec_i      [`NB_CORES],
  input  logic [`BANK_IDX_W-1:0]   bank_idx_i,
  output bank_req_t                bank_req_o,
  output logic [`NB_CORES-1:0]     winner_o
);

  logic [`NB_CORES-1:0]  cand;
  logic [`CORE_ID_W-1:0] ptr_q;
  logic [`CORE_ID_W-1:0] win_idx;
  logic                  found;

  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      cand[c] = dec_i[c].valid && (dec_i[c].tgt == TGT_TCDM) &&
                (dec_i[c].bank == bank_idx_i);
    end
  end

  // scan down from the farthest offset so the one nearest the pointer wins
  always_comb begin : pick
    logic [`CORE_ID_W-1:0] idx;
    found   = 1'b0;
    win_idx = ptr_q;
    for (int k = `NB_CORES - 1; k >= 0; k--) begin
      idx = ptr_q + `CORE_ID_W'(k);
      if (cand[idx]) begin
        found   = 1'b1;
        win_idx = idx;
      end
    end
  end

  // pointer moves past the winner, core count is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= win_idx + 1'b1;
    end
  end

  always_comb begin
    winner_o = '0;
    if (found) begin
      winner_o[win_idx] = 1'b1;
    end
  end

  always_comb begin
    bank_req_o.req   = found;
    bank_req_o.op    = core_req_i[win_idx].op;
    bank_req_o.word  = dec_i[win_idx].word;
    bank_req_o.wdata = core_req_i[win_idx].wdata;
    bank_req_o.be    = core_req_i[win_idx].be;
  end

endmodule

`default_nettype wire

//--- hw/cluster_intc_defines.svh
/*
 * cluster interconnect sizes and address map
 * core, bank and slave counts, word widths and the region windows
 */

`ifndef CLUSTER_INTC_DEFINES_SVH
`define CLUSTER_INTC_DEFINES_SVH

// requesters and targets
`define NB_CORES        4
`define NB_TCDM_BANKS   4
`define NB_SPERIPHS     4

// word and address widths
`define DATA_WIDTH      32
`define ADDR_WIDTH      32
`define BE_WIDTH        (`DATA_WIDTH / 8)
`define BANK_WORDS      256

// address map
`define CLUSTER_BASE    32'h1000_0000
`define PERIPH_OFFS     32'h0020_0000
`define PE_ROUTING_LSB  10
`define PERIPH_SPAN     (`NB_SPERIPHS * 1024)
`define TCDM_SPAN       (`NB_TCDM_BANKS * `BANK_WORDS * 4)

// derived index widths
`define BANK_IDX_W      $clog2(`NB_TCDM_BANKS)
`define WORD_IDX_W      $clog2(`BANK_WORDS)
`define SLAVE_IDX_W     $clog2(`NB_SPERIPHS)
`define CORE_ID_W       $clog2(`NB_CORES)

`endif

//--- hw/cluster_intc_pkg.sv
/*
 * cluster interconnect types
 * request, response and decode structs, target and opcode enums
 */

`default_nettype none

`include "cluster_intc_defines.svh"

package cluster_intc_pkg;

  typedef enum logic [1:0] {
    TGT_TCDM,
    TGT_PERIPH,
    TGT_NONE
  } target_e;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_e;

  // core side, plain req/gnt levels with an r_valid pulse
  typedef struct packed {
    logic                    req;
    op_e                     op;
    logic [`ADDR_WIDTH-1:0]  addr;
    logic [`DATA_WIDTH-1:0]  wdata;
    logic [`BE_WIDTH-1:0]    be;
  } core_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    r_valid;
    logic [`DATA_WIDTH-1:0]  r_rdata;
    logic                    r_err;
  } core_rsp_t;

  typedef struct packed {
    logic                    req;
    op_e                     op;
    logic [`WORD_IDX_W-1:0]  word;
    logic [`DATA_WIDTH-1:0]  wdata;
    logic [`BE_WIDTH-1:0]    be;
  } bank_req_t;

  // peripheral side carries the issuing core as id
  typedef struct packed {
    logic                    req;
    op_e                     op;
    logic [`ADDR_WIDTH-1:0]  addr;
    logic [`DATA_WIDTH-1:0]  wdata;
    logic [`BE_WIDTH-1:0]    be;
    logic [`CORE_ID_W-1:0]   id;
  } periph_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    r_valid;
    logic [`DATA_WIDTH-1:0]  r_rdata;
    logic [`CORE_ID_W-1:0]   r_id;
  } periph_rsp_t;

  typedef struct packed {
    logic                    valid;
    target_e                 tgt;
    logic [`BANK_IDX_W-1:0]  bank;
    logic [`WORD_IDX_W-1:0]  word;
    logic [`SLAVE_IDX_W-1:0] slave;
  } decode_t;

endpackage

`default_nettype wire

//--- hw/cluster_interconnect_top.sv
/*
 * cluster shared-memory interconnect
 * four cores to word-interleaved TCDM banks, peripheral slaves
 * and an error responder for unmapped addresses
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module cluster_interconnect_top import cluster_intc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  core_req_t   core_req_i    [`NB_CORES],
  output core_rsp_t   core_rsp_o    [`NB_CORES],
  output periph_req_t speriph_req_o [`NB_SPERIPHS],
  input  periph_rsp_t speriph_rsp_i [`NB_SPERIPHS]
);

  decode_t                dec        [`NB_CORES];
  bank_req_t              bank_req   [`NB_TCDM_BANKS];
  logic [`NB_CORES-1:0]   winner     [`NB_TCDM_BANKS];
  logic [`DATA_WIDTH-1:0] bank_rdata [`NB_TCDM_BANKS];
  logic [`NB_CORES-1:0]   p_gnt;
  logic [`NB_CORES-1:0]   p_rvalid;
  logic [`NB_CORES-1:0]   p_err;
  logic [`DATA_WIDTH-1:0] p_rdata    [`NB_CORES];

  // ******************************
  // address decode
  // ******************************
  for (genvar c = 0; c < `NB_CORES; c++) begin : gen_dec
    tcdm_addr_decode u_dec (
      .core_req_i ( core_req_i[c] ),
      .dec_o      ( dec[c]        )
    );
  end

  // ******************************
  // TCDM banks
  // ******************************
  for (genvar b = 0; b < `NB_TCDM_BANKS; b++) begin : gen_bank
    bank_rr_arbiter u_arb (
      .clk_i      ( clk_i              ),
      .rst_i      ( rst_i              ),
      .core_req_i ( core_req_i         ),
      .dec_i      ( dec                ),
      .bank_idx_i ( `BANK_IDX_W'(b)    ),
      .bank_req_o ( bank_req[b]        ),
      .winner_o   ( winner[b]          )
    );

    tcdm_bank_sram u_sram (
      .clk_i      ( clk_i         ),
      .bank_req_i ( bank_req[b]   ),
      .rdata_o    ( bank_rdata[b] )
    );
  end

  // peripherals and unmapped accesses
  periph_xbar u_xbar (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .core_req_i    ( core_req_i    ),
    .dec_i         ( dec           ),
    .speriph_req_o ( speriph_req_o ),
    .speriph_rsp_i ( speriph_rsp_i ),
    .p_gnt_o       ( p_gnt         ),
    .p_rvalid_o    ( p_rvalid      ),
    .p_err_o       ( p_err         ),
    .p_rdata_o     ( p_rdata       )
  );

  core_resp_merge u_merge (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .winner_i     ( winner     ),
    .bank_rdata_i ( bank_rdata ),
    .p_gnt_i      ( p_gnt      ),
    .p_rvalid_i   ( p_rvalid   ),
    .p_err_i      ( p_err      ),
    .p_rdata_i    ( p_rdata    ),
    .core_req_i   ( core_req_i ),
    .core_rsp_o   ( core_rsp_o )
  );

endmodule

`default_nettype wire

//--- hw/core_resp_merge.sv
/*
 * core response merge
 * combines bank and peripheral grants per core and returns the bank
 * response one cycle after its grant
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module core_resp_merge import cluster_intc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [`NB_CORES-1:0]   winner_i     [`NB_TCDM_BANKS],
  input  logic [`DATA_WIDTH-1:0] bank_rdata_i [`NB_TCDM_BANKS],
  input  logic [`NB_CORES-1:0]   p_gnt_i,
  input  logic [`NB_CORES-1:0]   p_rvalid_i,
  input  logic [`NB_CORES-1:0]   p_err_i,
  input  logic [`DATA_WIDTH-1:0] p_rdata_i    [`NB_CORES],
  input  core_req_t              core_req_i   [`NB_CORES],
  output core_rsp_t              core_rsp_o   [`NB_CORES]
);

  logic [`NB_CORES-1:0]   tcdm_gnt;
  logic [`NB_CORES-1:0]   tv_q;
  logic [`NB_CORES-1:0]   rd_q;
  logic [`BANK_IDX_W-1:0] gnt_bank [`NB_CORES];
  logic [`BANK_IDX_W-1:0] bank_q   [`NB_CORES];

  // a core wins at most one bank per cycle
  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      tcdm_gnt[c] = 1'b0;
      gnt_bank[c] = '0;
      for (int b = 0; b < `NB_TCDM_BANKS; b++) begin
        if (winner_i[b][c]) begin
          tcdm_gnt[c] = 1'b1;
          gnt_bank[c] = `BANK_IDX_W'(b);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tv_q <= '0;
    end else begin
      tv_q <= tcdm_gnt;
    end
  end

  // bank select and read flag of the access in flight
  always_ff @(posedge clk_i) begin
    for (int c = 0; c < `NB_CORES; c++) begin
      bank_q[c] <= gnt_bank[c];
      rd_q[c]   <= (core_req_i[c].op == OP_READ);
    end
  end

  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      core_rsp_o[c].gnt     = tcdm_gnt[c] | p_gnt_i[c];
      core_rsp_o[c].r_valid = tv_q[c] | p_rvalid_i[c];
      core_rsp_o[c].r_err   = p_err_i[c];
      if (tv_q[c]) begin
        // writes return zero
        core_rsp_o[c].r_rdata = rd_q[c] ? bank_rdata_i[bank_q[c]] : '0;
      end else begin
        core_rsp_o[c].r_rdata = p_rdata_i[c];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/periph_xbar.sv
/*
 * peripheral crossbar and error responder
 * fixed-priority routing of core requests to the slaves, response return
 * by id, and an immediate grant plus error reply for unmapped addresses
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module periph_xbar import cluster_intc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  core_req_t              core_req_i    [`NB_CORES],
  input  decode_t                dec_i         [`NB_CORES],
  output periph_req_t            speriph_req_o [`NB_SPERIPHS],
  input  periph_rsp_t            speriph_rsp_i [`NB_SPERIPHS],
  output logic [`NB_CORES-1:0]   p_gnt_o,
  output logic [`NB_CORES-1:0]   p_rvalid_o,
  output logic [`NB_CORES-1:0]   p_err_o,
  output logic [`DATA_WIDTH-1:0] p_rdata_o     [`NB_CORES]
);

  logic [`NB_CORES-1:0]    is_per;
  logic [`NB_CORES-1:0]    err_req;
  logic [`NB_CORES-1:0]    err_q;
  logic [`NB_CORES-1:0]    per_gnt;
  logic [`NB_CORES-1:0]    per_rvalid;
  logic [`NB_SPERIPHS-1:0] sel_valid;
  logic [`CORE_ID_W-1:0]   sel_id [`NB_SPERIPHS];

  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      is_per[c]  = dec_i[c].valid && (dec_i[c].tgt == TGT_PERIPH);
      err_req[c] = dec_i[c].valid && (dec_i[c].tgt == TGT_NONE);
    end
  end

  // ******************************
  // request path, lowest core wins
  // ******************************
  always_comb begin
    for (int s = 0; s < `NB_SPERIPHS; s++) begin
      sel_valid[s] = 1'b0;
      sel_id[s]    = '0;
      for (int c = `NB_CORES - 1; c >= 0; c--) begin
        if (is_per[c] && (dec_i[c].slave == `SLAVE_IDX_W'(s))) begin
          sel_valid[s] = 1'b1;
          sel_id[s]    = `CORE_ID_W'(c);
        end
      end
    end
  end

  always_comb begin
    for (int s = 0; s < `NB_SPERIPHS; s++) begin
      speriph_req_o[s].req   = sel_valid[s];
      speriph_req_o[s].op    = core_req_i[sel_id[s]].op;
      speriph_req_o[s].addr  = core_req_i[sel_id[s]].addr;
      speriph_req_o[s].wdata = core_req_i[sel_id[s]].wdata;
      speriph_req_o[s].be    = core_req_i[sel_id[s]].be;
      speriph_req_o[s].id    = sel_id[s];
    end
  end

  // slave grant goes back only to the core forwarded this cycle
  always_comb begin
    per_gnt = '0;
    for (int s = 0; s < `NB_SPERIPHS; s++) begin
      if (sel_valid[s] && speriph_rsp_i[s].gnt) begin
        per_gnt[sel_id[s]] = 1'b1;
      end
    end
  end

  // ******************************
  // response path, steered by r_id
  // ******************************
  always_comb begin
    per_rvalid = '0;
    for (int c = 0; c < `NB_CORES; c++) begin
      p_rdata_o[c] = '0;
    end
    for (int s = 0; s < `NB_SPERIPHS; s++) begin
      if (speriph_rsp_i[s].r_valid) begin
        per_rvalid[speriph_rsp_i[s].r_id] = 1'b1;
        p_rdata_o[speriph_rsp_i[s].r_id]  = speriph_rsp_i[s].r_rdata;
      end
    end
  end

  // error responder: granted now, answered next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= '0;
    end else begin
      err_q <= err_req;
    end
  end

  assign p_gnt_o    = per_gnt | err_req;
  assign p_rvalid_o = per_rvalid | err_q;
  assign p_err_o    = err_q;

endmodule

`default_nettype wire

//--- hw/tcdm_addr_decode.sv
/*
 * core address decoder
 * classifies one core request as TCDM, peripheral or unmapped and
 * extracts bank, in-bank word and slave indices
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module tcdm_addr_decode import cluster_intc_pkg::*; (
  input  core_req_t core_req_i,
  output decode_t   dec_o
);

  logic [`ADDR_WIDTH-1:0] tcdm_offs;
  logic [`ADDR_WIDTH-1:0] per_offs;
  logic                   in_tcdm;
  logic                   in_periph;

  // offsets wrap below the base, so one unsigned compare bounds each window
  assign tcdm_offs = core_req_i.addr - `CLUSTER_BASE;
  assign per_offs  = core_req_i.addr - (`CLUSTER_BASE + `PERIPH_OFFS);

  assign in_tcdm   = tcdm_offs < `TCDM_SPAN;
  assign in_periph = per_offs < `PERIPH_SPAN;

  always_comb begin
    dec_o.valid = core_req_i.req;

    // word interleaving: low word bits select the bank
    dec_o.bank  = tcdm_offs[2 +: `BANK_IDX_W];
    dec_o.word  = tcdm_offs[2 + `BANK_IDX_W +: `WORD_IDX_W];

    // one 1 KiB page per slave
    dec_o.slave = per_offs[`PE_ROUTING_LSB +: `SLAVE_IDX_W];

    if (in_tcdm) begin
      dec_o.tgt = TGT_TCDM;
    end else if (in_periph) begin
      dec_o.tgt = TGT_PERIPH;
    end else begin
      dec_o.tgt = TGT_NONE;
    end
  end

endmodule

`default_nettype wire

//--- hw/tcdm_bank_sram.sv
/*
 * TCDM bank
 * synchronous single-port SRAM with byte enables, read data one cycle later
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module tcdm_bank_sram import cluster_intc_pkg::*; (
  input  logic                   clk_i,
  input  bank_req_t              bank_req_i,
  output logic [`DATA_WIDTH-1:0] rdata_o
);

  logic [`DATA_WIDTH-1:0] mem [`BANK_WORDS];
  logic [`DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (bank_req_i.req) begin
      if (bank_req_i.op == OP_WRITE) begin
        for (int b = 0; b < `BE_WIDTH; b++) begin
          if (bank_req_i.be[b]) begin
            mem[bank_req_i.word][8*b +: 8] <= bank_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[bank_req_i.word];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module cluster_intc_tb -Mdir obj_dir

out=$(./obj_dir/Vcluster_intc_tb)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi

//--- verif/cluster_intc_sva.sv
/*
 * interconnect protocol assertions
 * TCDM response timing, quiet outputs in reset, request hold until grant
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module cluster_intc_sva import cluster_intc_pkg::*; (
  input logic      clk_i,
  input logic      rst_i,
  input core_req_t core_req_i [`NB_CORES],
  input core_rsp_t core_rsp_o [`NB_CORES]
);

  timeunit 1ns;
  timeprecision 1ps;

  for (genvar c = 0; c < `NB_CORES; c++) begin : gen_core
    logic in_tcdm;

    assign in_tcdm = (core_req_i[c].addr - `CLUSTER_BASE) < `TCDM_SPAN;

    a_tcdm_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
      core_rsp_o[c].gnt && in_tcdm |=> core_rsp_o[c].r_valid && !core_rsp_o[c].r_err)
      else $error("core %0d: TCDM response not one cycle after grant", c);

    // first reset cycle still holds power-up state
    a_quiet_rst: assert property (@(posedge clk_i)
      rst_i && $past(rst_i) |-> !core_rsp_o[c].gnt && !core_rsp_o[c].r_valid)
      else $error("core %0d: grant or response during reset", c);

    a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      core_req_i[c].req && !core_rsp_o[c].gnt |=> $stable(core_req_i[c]))
      else $error("core %0d: request changed before grant", c);
  end

endmodule

`default_nettype wire

//--- verif/cluster_intc_tb.sv
/*
 * cluster interconnect testbench
 * core drivers, peripheral slave model, shadow TCDM and response compare
 */

`default_nettype none

`include "cluster_intc_defines.svh"

module cluster_intc_tb import cluster_intc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TOTAL_REQ = 300;
  localparam int DRV_DLY   = 2;

  logic        clk_i;
  logic        rst_i;
  core_req_t   core_req [`NB_CORES];
  core_rsp_t   core_rsp [`NB_CORES];
  periph_req_t sp_req   [`NB_SPERIPHS];
  periph_rsp_t sp_rsp   [`NB_SPERIPHS];

  logic [31:0] lfsr;
  logic [31:0] shadow [1024];
  logic [32:0] exp_q [`NB_CORES][$];
  int          grant_log [$];
  bit          log_grants;
  int          errors;
  int          checks;
  int          err_mark;
  int          chk_mark;

  // traffic lists filled before the cores start
  op_e         t_op    [`NB_CORES][24];
  logic [31:0] t_addr  [`NB_CORES][24];
  logic [31:0] t_wdata [`NB_CORES][24];
  logic [3:0]  t_be    [`NB_CORES][24];

  // slave model state per slave and core
  logic        pend  [`NB_SPERIPHS][`NB_CORES];
  int          cnt   [`NB_SPERIPHS][`NB_CORES];
  logic [31:0] pdata [`NB_SPERIPHS][`NB_CORES];

  cluster_interconnect_top u_dut (
    .clk_i         ( clk_i    ),
    .rst_i         ( rst_i    ),
    .core_req_i    ( core_req ),
    .core_rsp_o    ( core_rsp ),
    .speriph_req_o ( sp_req   ),
    .speriph_rsp_i ( sp_rsp   )
  );

  bind cluster_interconnect_top cluster_intc_sva u_sva (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ******************************
  // helpers and reference model
  // ******************************
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic logic [31:0] scramble(input logic [31:0] addr, input int slave);
    return {addr[15:0], addr[31:16]} ^ (32'h3c5a_0000 + slave * 32'h0101);
  endfunction

  // {r_err, r_rdata} that the rules of the address map give
  function automatic logic [32:0] expected_rdata(input op_e op, input logic [31:0] addr);
    logic [31:0] offs;
    logic [31:0] poffs;
    offs  = addr - `CLUSTER_BASE;
    poffs = addr - (`CLUSTER_BASE + `PERIPH_OFFS);
    if (offs < `TCDM_SPAN) begin
      return {1'b0, (op == OP_READ) ? shadow[offs[11:2]] : 32'h0};
    end else if (poffs < `PERIPH_SPAN) begin
      return {1'b0, (op == OP_READ) ? scramble(addr, int'(poffs[11:10])) : 32'h0};
    end
    return {1'b1, 32'h0};
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
    logic [31:0] offs;
    offs = addr - `CLUSTER_BASE;
    if (offs < `TCDM_SPAN) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) shadow[offs[11:2]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // drives one request until granted and returns at the next drive point
  task automatic access(input int c, input op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] be,
                        input bit wait_rsp, output int waited);
    core_req[c].op    = op;
    core_req[c].addr  = addr;
    core_req[c].wdata = wdata;
    core_req[c].be    = be;
    core_req[c].req   = 1'b1;
    waited = 0;
    forever begin
      @(negedge clk_i);
      if (core_rsp[c].gnt) break;
      waited++;
    end
    exp_q[c].push_back(expected_rdata(op, addr));
    if (op == OP_WRITE) shadow_write(addr, wdata, be);
    if (log_grants) grant_log.push_back(c);
    @(posedge clk_i);
    #DRV_DLY;
    core_req[c].req = 1'b0;
    while (wait_rsp && exp_q[c].size() != 0) begin
      @(posedge clk_i);
      #DRV_DLY;
    end
  endtask

  task automatic run_list(input int c, input int n, input bit wait_rsp);
    int waited;
    for (int i = 0; i < n; i++) begin
      access(c, t_op[c][i], t_addr[c][i], t_wdata[c][i], t_be[c][i], wait_rsp, waited);
    end
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #DRV_DLY;
    rst_i = 1'b0;
  endtask

  task automatic close_test(input string name);
    int guard;
    int left;
    guard = 0;
    left  = 1;
    while (left != 0 && guard < 20) begin
      left = 0;
      for (int c = 0; c < `NB_CORES; c++) left += exp_q[c].size();
      @(posedge clk_i);
      #DRV_DLY;
      guard++;
    end
    if (left != 0) begin
      errors++;
      $display("test %s: %0d responses never arrived", name, left);
    end
    $display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
    chk_mark = checks;
    err_mark = errors;
  endtask

  // ******************************
  // compare and slave model
  // ******************************
  always @(negedge clk_i) begin
    if (!rst_i) begin
      for (int c = 0; c < `NB_CORES; c++) begin
        if (core_rsp[c].r_valid) begin
          if (exp_q[c].size() == 0) begin
            errors++;
            $display("core %0d got a response with no request outstanding at %0t", c, $time);
          end else begin
            check($sformatf("core %0d response", c), {core_rsp[c].r_err, core_rsp[c].r_rdata},
                  exp_q[c].pop_front());
          end
        end
      end
    end
  end

  initial begin
    int id;
    int sel;
    for (int s = 0; s < `NB_SPERIPHS; s++) begin
      sp_rsp[s] = '0;
      sp_rsp[s].gnt = 1'b1;
      for (int c = 0; c < `NB_CORES; c++) pend[s][c] = 1'b0;
    end
    forever begin
      @(posedge clk_i);
      #DRV_DLY;
      for (int s = 0; s < `NB_SPERIPHS; s++) begin
        sp_rsp[s].r_valid = 1'b0;
        sel = -1;
        for (int c = `NB_CORES - 1; c >= 0; c--) begin
          if (pend[s][c] && cnt[s][c] > 0) cnt[s][c]--;
          if (pend[s][c] && cnt[s][c] == 0) sel = c;
        end
        if (sel >= 0 && !rst_i) begin
          sp_rsp[s].r_valid = 1'b1;
          sp_rsp[s].r_id    = sel[1:0];
          sp_rsp[s].r_rdata = pdata[s][sel];
          pend[s][sel]      = 1'b0;
        end
      end
      @(negedge clk_i);
      for (int s = 0; s < `NB_SPERIPHS; s++) begin
        if (sp_req[s].req && !rst_i) begin
          id = int'(sp_req[s].id);
          check($sformatf("slave %0d id", s), {core_req[id].req, core_rsp[id].gnt,
                core_req[id].addr}, {2'b11, sp_req[s].addr});
          check($sformatf("slave %0d write data", s), {core_req[id].be, core_req[id].wdata},
                {sp_req[s].be, sp_req[s].wdata});
          pend[s][id]  = 1'b1;
          cnt[s][id]   = 1 + int'(rand_bits(2));
          pdata[s][id] = (sp_req[s].op == OP_READ) ? scramble(sp_req[s].addr, s) : 32'h0;
        end
      end
    end
  end

  initial begin
    repeat (TOTAL_REQ * 10 + 200) @(posedge clk_i);
    $display("timeout: the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

  // ******************************
  // test sequence
  // ******************************
  initial begin
    int          waited;
    logic [31:0] unmapped [8];
    lfsr = 32'h6b61;
    errors = 0;
    checks = 0;
    err_mark = 0;
    chk_mark = 0;
    log_grants = 1'b0;
    for (int c = 0; c < `NB_CORES; c++) core_req[c] = '0;
    apply_reset();

    // single core writes full and partial words across all banks then reads back
    for (int w = 0; w < 64; w++) begin
      access(0, OP_WRITE, `CLUSTER_BASE + w * 4, rand_bits(32), 4'hf, 1'b0, waited);
    end
    for (int i = 0; i < 16; i++) begin
      access(0, OP_WRITE, `CLUSTER_BASE + rand_bits(6) * 4, rand_bits(32), rand_bits(4),
             1'b0, waited);
    end
    for (int w = 0; w < 64; w++) begin
      access(0, OP_READ, `CLUSTER_BASE + w * 4, 32'h0, 4'h0, 1'b0, waited);
    end
    close_test("single core banks");

    // all cores on bank 0 in round robin order from core 0
    apply_reset();
    grant_log.delete();
    log_grants = 1'b1;
    for (int c = 0; c < `NB_CORES; c++) begin
      for (int k = 0; k < 4; k++) begin
        t_op[c][k]    = OP_READ;
        t_addr[c][k]  = `CLUSTER_BASE + 16 * (c * 4 + k);
        t_wdata[c][k] = 32'h0;
        t_be[c][k]    = 4'h0;
      end
    end
    fork
      run_list(0, 4, 1'b0);
      run_list(1, 4, 1'b0);
      run_list(2, 4, 1'b0);
      run_list(3, 4, 1'b0);
    join
    log_grants = 1'b0;
    for (int k = 0; k < grant_log.size(); k++) begin
      check($sformatf("grant %0d owner", k), grant_log[k], k % 4);
    end
    close_test("bank round robin");

    // first half on a private bank and second half on any bank
    for (int c = 0; c < `NB_CORES; c++) begin
      for (int i = 0; i < 24; i++) begin
        t_op[c][i]    = op_e'(rand_bits(1));
        t_addr[c][i]  = `CLUSTER_BASE + 16 * rand_bits(4) +
                        4 * ((i < 12) ? c : int'(rand_bits(2)));
        t_wdata[c][i] = rand_bits(32);
        t_be[c][i]    = rand_bits(4);
      end
    end
    fork
      run_list(0, 24, 1'b0);
      run_list(1, 24, 1'b0);
      run_list(2, 24, 1'b0);
      run_list(3, 24, 1'b0);
    join
    close_test("random TCDM traffic");

    for (int c = 0; c < `NB_CORES; c++) begin
      for (int i = 0; i < 8; i++) begin
        t_op[c][i]    = op_e'(rand_bits(1));
        t_addr[c][i]  = `CLUSTER_BASE + `PERIPH_OFFS + 1024 * rand_bits(2) + 4 * rand_bits(8);
        t_wdata[c][i] = rand_bits(32);
        t_be[c][i]    = 4'hf;
      end
    end
    fork
      run_list(0, 8, 1'b1);
      run_list(1, 8, 1'b1);
      run_list(2, 8, 1'b1);
      run_list(3, 8, 1'b1);
    join
    close_test("peripheral traffic");

    // addresses just outside each window and far away
    unmapped[0] = 32'h0000_0100;
    unmapped[1] = `CLUSTER_BASE - 4;
    unmapped[2] = `CLUSTER_BASE + `TCDM_SPAN;
    unmapped[3] = `CLUSTER_BASE + `PERIPH_OFFS - 4;
    unmapped[4] = `CLUSTER_BASE + `PERIPH_OFFS + `PERIPH_SPAN;
    unmapped[5] = 32'h2000_0000;
    unmapped[6] = 32'hffff_fffc;
    unmapped[7] = `CLUSTER_BASE + 32'h0010_0000;
    for (int i = 0; i < 8; i++) begin
      access(i % 4, op_e'(i[0]), unmapped[i], rand_bits(32), 4'hf, 1'b1, waited);
      check("unmapped grant wait", waited, 0);
    end
    for (int w = 0; w < 4; w++) begin
      access(0, OP_READ, `CLUSTER_BASE + w * 4, 32'h0, 4'h0, 1'b0, waited);
    end
    close_test("unmapped accesses");

    $display("%0d checks, %0d errors in total", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/cluster_intc_pkg.sv
hw/tcdm_addr_decode.sv
hw/bank_rr_arbiter.sv
hw/tcdm_bank_sram.sv
hw/periph_xbar.sv
hw/core_resp_merge.sv
hw/cluster_interconnect_top.sv
verif/cluster_intc_sva.sv
verif/cluster_intc_tb.sv
